//--- Makefile
# Verilator build and run for the decode-to-execute slice

TOP             ?= tb_decodeExecute
SIM_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

FILE_LIST := tb.f
SOURCES   := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS   := $(wildcard *.svh)
BIN       := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(SIM_DIR)

//--- controlDecode.sv
// instruction decoder that builds the ID/EX bundle from the fetched word and register reads
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module controlDecode (
  input  logic               instrValid,
  input  cpuTypesPkg::wordT  instr,
  input  cpuTypesPkg::wordT  pc,
  output logic [`REG_AW-1:0] rsAddr,
  output logic [`REG_AW-1:0] rtAddr,
  input  cpuTypesPkg::wordT  rdat1,
  input  cpuTypesPkg::wordT  rdat2,
  pipeRegIf.writer           idEx
);

  cpuTypesPkg::opcodeT opcode;
  cpuTypesPkg::functT  funct;
  logic [15:0]         imm16;

  assign opcode = cpuTypesPkg::opcodeT'(instr[31:26]);
  assign funct  = cpuTypesPkg::functT'(instr[5:0]);
  assign imm16  = instr[15:0];
  assign rsAddr = instr[25:21];
  assign rtAddr = instr[20:16];

  assign idEx.pc    = pc;
  assign idEx.rdat1 = rdat1;
  assign idEx.rdat2 = rdat2;

  // ****************************************
  // control, destination and immediate
  // ****************************************
  always_comb
  begin
    idEx.ctrl       = '0;
    idEx.ctrl.valid = instrValid;
    idEx.dest       = '0;
    idEx.imm        = {{16{imm16[15]}}, imm16};   // sign extension unless overridden
    case (opcode)
      cpuTypesPkg::OP_RTYPE:
      begin
        idEx.ctrl.regWrite = 1'b1;
        idEx.dest          = instr[15:11];
        case (funct)
          cpuTypesPkg::FN_ADD: idEx.ctrl.aluOp = cpuTypesPkg::ALU_ADD;
          cpuTypesPkg::FN_SUB: idEx.ctrl.aluOp = cpuTypesPkg::ALU_SUB;
          cpuTypesPkg::FN_AND: idEx.ctrl.aluOp = cpuTypesPkg::ALU_AND;
          cpuTypesPkg::FN_OR:  idEx.ctrl.aluOp = cpuTypesPkg::ALU_OR;
          cpuTypesPkg::FN_SLT: idEx.ctrl.aluOp = cpuTypesPkg::ALU_SLT;
          default:             idEx.ctrl = '0;   // unsupported funct goes down as a bubble
        endcase
      end
      cpuTypesPkg::OP_ADDI, cpuTypesPkg::OP_ORI, cpuTypesPkg::OP_LUI:
      begin
        idEx.ctrl.regWrite = 1'b1;
        idEx.ctrl.aluSrc   = 1'b1;
        idEx.dest          = rtAddr;
        if (opcode == cpuTypesPkg::OP_ORI)
        begin
          idEx.ctrl.aluOp = cpuTypesPkg::ALU_OR;
          idEx.imm        = {16'h0000, imm16};
        end
        else if (opcode == cpuTypesPkg::OP_LUI)
        begin
          idEx.ctrl.aluOp = cpuTypesPkg::ALU_PASSB;
          idEx.imm        = {imm16, 16'h0000};
        end
      end
      cpuTypesPkg::OP_BEQ, cpuTypesPkg::OP_BNE:
      begin
        idEx.ctrl.branch = 1'b1;
        idEx.ctrl.bne    = (opcode == cpuTypesPkg::OP_BNE);
        idEx.ctrl.aluOp  = cpuTypesPkg::ALU_SUB;
      end
      cpuTypesPkg::OP_J:
      begin
        idEx.ctrl.jmp = 1'b1;
        idEx.imm      = {6'b000000, instr[25:0]};   // jump index carried in imm
      end
      default: idEx.ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- cpuTypesPkg.sv
// shared opcode, funct, ALU operation and ID/EX control types for the integer core
`default_nettype none

`include "cpu_params.svh"

package cpuTypesPkg;

  typedef logic [`WORD_W-1:0] wordT;

  // ****************************************
  // instruction encodings
  // ****************************************
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDI  = 6'h08,
    OP_ORI   = 6'h0D,
    OP_LUI   = 6'h0F
  } opcodeT;

  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2A
  } functT;

  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,   // zero so a cleared bundle decodes as add
    ALU_SUB   = 3'd1,
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_SLT   = 3'd4,
    ALU_PASSB = 3'd5    // used by LUI, operand b already shifted
  } aluOpT;

  typedef struct packed {
    logic  valid;
    logic  regWrite;
    logic  aluSrc;   // immediate replaces rdat2 as operand b
    logic  branch;
    logic  bne;
    logic  jmp;
    aluOpT aluOp;
  } idExCtrlT;

endpackage

`default_nettype wire

//--- cpu_params.svh
// core-wide width and register file size definitions for the decode/execute slice
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width of the core
`define WORD_W 32

`define REG_AW 5   // register address width
`define NUM_REGS 32   // architectural registers, r0 included

`endif

//--- decodeExecute.sv
// decode-to-execute slice top level joining decode, ID/EX register, execute and register file
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decodeExecute (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               instrValid,
  input  cpuTypesPkg::wordT  instr,
  input  cpuTypesPkg::wordT  pc,
  output logic               instrReady,
  output logic               resValid,
  output cpuTypesPkg::wordT  resData,
  output logic [`REG_AW-1:0] resDest,
  output cpuTypesPkg::wordT  resPc,
  input  logic               resReady,
  output logic               redirectValid,
  output cpuTypesPkg::wordT  redirectPc
);

  logic [`REG_AW-1:0] rsAddr;
  logic [`REG_AW-1:0] rtAddr;
  cpuTypesPkg::wordT  rdat1;
  cpuTypesPkg::wordT  rdat2;
  logic               wbEn;
  logic [`REG_AW-1:0] wbAddr;
  cpuTypesPkg::wordT  wbData;
  logic               enable;
  logic               flush;

  pipeRegIf idExIn ();    // decode side of the ID/EX register
  pipeRegIf idExOut ();   // execute side

  registerFile i_registerFile (
    .CLK(CLK), .nRST(nRST),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .rdat1(rdat1), .rdat2(rdat2),
    .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
  );

  controlDecode i_controlDecode (
    .instrValid(instrValid), .instr(instr), .pc(pc),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .rdat1(rdat1), .rdat2(rdat2),
    .idEx(idExIn.writer)
  );

  pipeRegIdEx i_pipeRegIdEx (
    .CLK(CLK), .nRST(nRST),
    .prIdExIn(idExIn.reader), .prIdExOut(idExOut.writer),
    .enable(enable), .flush(flush)
  );

  executeStage i_executeStage (
    .idEx(idExOut.reader), .resReady(resReady),
    .resValid(resValid), .resData(resData), .resPc(resPc), .resDest(resDest),
    .redirect(redirectValid), .redirectPc(redirectPc),
    .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
  );

  pipelineControl i_pipelineControl (
    .exValid(idExOut.ctrl.valid), .resReady(resReady),
    .redirect(redirectValid), .instrValid(instrValid),
    .enable(enable), .flush(flush), .instrReady(instrReady)
  );

endmodule

`default_nettype wire

//--- executeStage.sv
// execute stage with ALU, branch and jump resolution, result handshake and writeback request
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module executeStage (
  pipeRegIf.reader           idEx,
  input  logic               resReady,
  output logic               resValid,
  output cpuTypesPkg::wordT  resData,
  output cpuTypesPkg::wordT  resPc,
  output logic [`REG_AW-1:0] resDest,
  output logic               redirect,
  output cpuTypesPkg::wordT  redirectPc,
  output logic               wbEn,
  output logic [`REG_AW-1:0] wbAddr,
  output cpuTypesPkg::wordT  wbData
);

  cpuTypesPkg::wordT opB;
  cpuTypesPkg::wordT aluOut;
  cpuTypesPkg::wordT pcPlus4;
  logic              taken;

  assign opB = idEx.ctrl.aluSrc ? idEx.imm : idEx.rdat2;

  // ****************************************
  // ALU
  // ****************************************
  always_comb
  begin
    case (idEx.ctrl.aluOp)
      cpuTypesPkg::ALU_ADD:   aluOut = idEx.rdat1 + opB;
      cpuTypesPkg::ALU_SUB:   aluOut = idEx.rdat1 - opB;
      cpuTypesPkg::ALU_AND:   aluOut = idEx.rdat1 & opB;
      cpuTypesPkg::ALU_OR:    aluOut = idEx.rdat1 | opB;
      cpuTypesPkg::ALU_SLT:   aluOut = {{(`WORD_W-1){1'b0}}, $signed(idEx.rdat1) < $signed(opB)};
      cpuTypesPkg::ALU_PASSB: aluOut = opB;
      default:                aluOut = '0;
    endcase
  end

  // branch compares the register operands directly, BNE flips the sense
  assign pcPlus4 = idEx.pc + cpuTypesPkg::wordT'(4);
  assign taken   = idEx.ctrl.jmp |
                   (idEx.ctrl.branch & ((idEx.rdat1 == idEx.rdat2) ^ idEx.ctrl.bne));

  assign redirect   = resValid & taken;
  assign redirectPc = idEx.ctrl.jmp ?
                      {pcPlus4[`WORD_W-1 -: 4], idEx.imm[25:0], 2'b00} :
                      pcPlus4 + {idEx.imm[`WORD_W-3:0], 2'b00};

  // ****************************************
  // result and writeback
  // ****************************************
  assign resValid = idEx.ctrl.valid;
  assign resPc    = idEx.pc;
  assign resData  = idEx.ctrl.regWrite ? aluOut : '0;   // branches and jumps report zero
  assign resDest  = idEx.ctrl.regWrite ? idEx.dest : '0;

  assign wbEn   = resValid & resReady & idEx.ctrl.regWrite;   // commit on the accepting edge
  assign wbAddr = idEx.dest;
  assign wbData = aluOut;

endmodule

`default_nettype wire

//--- pipeRegIdEx.sv
// ID/EX pipeline register with load enable, bubble insertion and asynchronous reset
`timescale 1ns/1ps
`default_nettype none

module pipeRegIdEx (
  input logic        CLK,
  input logic        nRST,
  pipeRegIf.reader   prIdExIn,
  pipeRegIf.writer   prIdExOut,
  input logic        enable,
  input logic        flush
);

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      prIdExOut.ctrl  <= '0;
      prIdExOut.pc    <= '0;
      prIdExOut.rdat1 <= '0;
      prIdExOut.rdat2 <= '0;
      prIdExOut.imm   <= '0;
      prIdExOut.dest  <= '0;
    end
    else if (enable)
    begin
      if (flush)
      begin
        prIdExOut.ctrl  <= '0;   // bubble, nothing valid reaches execute
        prIdExOut.pc    <= '0;
        prIdExOut.rdat1 <= '0;
        prIdExOut.rdat2 <= '0;
        prIdExOut.imm   <= '0;
        prIdExOut.dest  <= '0;
      end
      else
      begin
        prIdExOut.ctrl  <= prIdExIn.ctrl;
        prIdExOut.pc    <= prIdExIn.pc;
        prIdExOut.rdat1 <= prIdExIn.rdat1;
        prIdExOut.rdat2 <= prIdExIn.rdat2;
        prIdExOut.imm   <= prIdExIn.imm;
        prIdExOut.dest  <= prIdExIn.dest;
      end
    end
  end

  // a stalled stage keeps its instruction even if a flush is requested
  flushNeedsEnable: assert property (@(posedge CLK) disable iff (!nRST)
    !enable |=> $stable(prIdExOut.ctrl));

endmodule

`default_nettype wire

//--- pipeRegIf.sv
// decoded instruction bundle passed between decode, the ID/EX register and execute
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

interface pipeRegIf;

  cpuTypesPkg::idExCtrlT    ctrl;
  cpuTypesPkg::wordT        pc;
  cpuTypesPkg::wordT        rdat1;
  cpuTypesPkg::wordT        rdat2;
  cpuTypesPkg::wordT        imm;    // already extended, shifted for LUI
  logic [`REG_AW-1:0]       dest;   // zero when nothing is written back

  // producer side of the bundle
  modport writer (
    output ctrl, pc, rdat1, rdat2, imm, dest
  );

  modport reader (
    input ctrl, pc, rdat1, rdat2, imm, dest
  );

endinterface

`default_nettype wire

//--- pipelineControl.sv
// stall and flush policy for the ID/EX register and the fetch handshake
`timescale 1ns/1ps
`default_nettype none

module pipelineControl (
  input  logic exValid,
  input  logic resReady,
  input  logic redirect,
  input  logic instrValid,
  output logic enable,
  output logic flush,
  output logic instrReady
);

  // ID/EX advances when execute is empty or its result leaves this cycle
  assign enable = !exValid || resReady;

  // nothing offered, or the offered word is on the wrong path
  assign flush = enable && (!instrValid || redirect);

  assign instrReady = enable && !redirect;   // fetch waits one cycle on a redirect

  // ****************************************
  // checks
  // ****************************************
  // a redirect can only come from a valid instruction sitting in execute
  always_comb
  begin
    redirectFromValid: assert final (!redirect || exValid)
      else $error("redirect raised while execute holds no instruction");
  end

endmodule

`default_nettype wire

//--- registerFile.sv
// 32-entry register file with two read ports, one write port and write-through bypass
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module registerFile (
  input  logic               CLK,
  input  logic               nRST,
  input  logic [`REG_AW-1:0] rsAddr,
  input  logic [`REG_AW-1:0] rtAddr,
  output cpuTypesPkg::wordT  rdat1,
  output cpuTypesPkg::wordT  rdat2,
  input  logic               wbEn,
  input  logic [`REG_AW-1:0] wbAddr,
  input  cpuTypesPkg::wordT  wbData
);

  cpuTypesPkg::wordT regs [`NUM_REGS];

  // r0 is hardwired, and a write in flight is forwarded to the reader
  function automatic cpuTypesPkg::wordT readPort(input logic [`REG_AW-1:0] addr);
    if (addr == '0)
      return '0;
    if (wbEn && (wbAddr == addr))
      return wbData;
    return regs[addr];
  endfunction

  always_comb
  begin
    rdat1 = readPort(rsAddr);
    rdat2 = readPort(rtAddr);
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wbEn && (wbAddr != '0))
      regs[wbAddr] <= wbData;   // writes to r0 are dropped
  end

  // execute must never hand an undefined result to the accepting edge
  wbDataKnown: assert property (@(posedge CLK) disable iff (!nRST)
    wbEn |-> !$isunknown(wbData));

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
cpuTypesPkg.sv
pipeRegIf.sv
registerFile.sv
controlDecode.sv
pipeRegIdEx.sv
executeStage.sv
pipelineControl.sv
decodeExecute.sv
tb_decodeExecute.sv

//--- tb_decodeExecute.sv
// table-driven testbench for the decode-to-execute slice with a reference register model
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_decodeExecute;

  typedef struct packed {
    cpuTypesPkg::wordT  instr;
    cpuTypesPkg::wordT  pc;
    logic               valid;       // low marks an idle cycle for the fetcher
    logic               ready;       // resReady for the first cycle the row is offered
    cpuTypesPkg::wordT  expData;
    logic [`REG_AW-1:0] expDest;
    logic               expRedir;
    cpuTypesPkg::wordT  expTarget;
  } rowT;

  logic               CLK;
  logic               nRST;
  logic               instrValid;
  cpuTypesPkg::wordT  instr;
  cpuTypesPkg::wordT  pc;
  logic               instrReady;
  logic               resValid;
  cpuTypesPkg::wordT  resData;
  logic [`REG_AW-1:0] resDest;
  cpuTypesPkg::wordT  resPc;
  logic               resReady;
  logic               redirectValid;
  cpuTypesPkg::wordT  redirectPc;

  rowT               rows[$];
  string             names[$];
  int                pending[$];   // row indices accepted but not yet taken
  cpuTypesPkg::wordT refRegs [`NUM_REGS];
  cpuTypesPkg::wordT nextPc;
  logic [31:0]       rngState;
  int                cycles = 0;
  int                cycleLimit = 1000;
  int                acceptedCount = 0;
  int                takenCount = 0;
  int                validRows = 0;

  decodeExecute i_decodeExecute (
    .CLK(CLK), .nRST(nRST),
    .instrValid(instrValid), .instr(instr), .pc(pc), .instrReady(instrReady),
    .resValid(resValid), .resData(resData), .resDest(resDest), .resPc(resPc),
    .resReady(resReady), .redirectValid(redirectValid), .redirectPc(redirectPc)
  );

  always #5 CLK = ~CLK;   // 10 ns period

  always @(posedge CLK)
  begin
    cycles <= cycles + 1;
    if (cycles > cycleLimit)
      abortRun($sformatf("timeout after %0d cycles with %0d results outstanding",
                         cycles, pending.size()));
  end

  // handshakes counted at the DUT's own edges, apart from the table walk
  always @(posedge CLK)
  begin
    if (nRST && instrValid && instrReady)
      acceptedCount++;
    if (nRST && resValid && resReady)
      takenCount++;
  end

  // ****************************************
  // reporting and compare tasks
  // ****************************************
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input cpuTypesPkg::wordT exp,
                           input cpuTypesPkg::wordT act);
    if (act !== exp)
      abortRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic checkDest(input string name, input logic [`REG_AW-1:0] exp,
                           input logic [`REG_AW-1:0] act);
    if (act !== exp)
      abortRun($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp)
      abortRun($sformatf("mismatch %s expected %b actual %b", name, exp, act));
  endtask

  // ****************************************
  // instruction encoding and the stimulus table
  // ****************************************
  function automatic cpuTypesPkg::wordT rType(input cpuTypesPkg::functT fn, input int rs,
                                              input int rt, input int rd);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
  endfunction

  function automatic cpuTypesPkg::wordT iType(input cpuTypesPkg::opcodeT op, input int rs,
                                              input int rt, input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic addInstr(input string name, input cpuTypesPkg::wordT word, input logic rdy,
                          input cpuTypesPkg::wordT expData, input int expDest,
                          input logic expRedir, input cpuTypesPkg::wordT expTarget);
    rowT r;
    r.instr     = word;
    r.pc        = nextPc;
    r.valid     = 1'b1;
    r.ready     = rdy;
    r.expData   = expData;
    r.expDest   = expDest[`REG_AW-1:0];
    r.expRedir  = expRedir;
    r.expTarget = expTarget;
    rows.push_back(r);
    names.push_back(name);
    validRows++;
    if (expDest != 0)
      refRegs[expDest] = expData;   // the model follows the committed results
    nextPc = expRedir ? expTarget : nextPc + 32'd4;   // fetcher follows a redirect
  endtask

  task automatic addIdle(input logic rdy);
    rowT r;
    r       = '0;
    r.ready = rdy;
    rows.push_back(r);
    names.push_back("idle");
  endtask

  task automatic buildTable();
    nextPc = 32'h0000_0100;
    addInstr("addi from r0", iType(cpuTypesPkg::OP_ADDI, 0, 1, 16'h0005), 1'b1, 32'h5, 1, 1'b0, '0);
    addInstr("addi sign", iType(cpuTypesPkg::OP_ADDI, 0, 2, 16'hFFFD), 1'b1,
             32'hFFFF_FFFD, 2, 1'b0, '0);
    addInstr("add bypass", rType(cpuTypesPkg::FN_ADD, 1, 2, 3), 1'b1, 32'h2, 3, 1'b0, '0);
    addInstr("sub", rType(cpuTypesPkg::FN_SUB, 1, 2, 4), 1'b1, 32'h8, 4, 1'b0, '0);
    addInstr("or", rType(cpuTypesPkg::FN_OR, 3, 4, 5), 1'b1, 32'hA, 5, 1'b0, '0);
    addInstr("and", rType(cpuTypesPkg::FN_AND, 4, 5, 6), 1'b1, 32'h8, 6, 1'b0, '0);
    addInstr("slt true", rType(cpuTypesPkg::FN_SLT, 2, 1, 7), 1'b1, 32'h1, 7, 1'b0, '0);
    addInstr("slt false", rType(cpuTypesPkg::FN_SLT, 1, 2, 8), 1'b1, 32'h0, 8, 1'b0, '0);
    addInstr("ori zext", iType(cpuTypesPkg::OP_ORI, 0, 9, 16'h8001), 1'b1,
             32'h0000_8001, 9, 1'b0, '0);
    addInstr("lui", iType(cpuTypesPkg::OP_LUI, 0, 10, 16'h1234), 1'b1,
             32'h1234_0000, 10, 1'b0, '0);
    addInstr("addi to r0", iType(cpuTypesPkg::OP_ADDI, 1, 0, 16'h0007), 1'b1, 32'hC, 0, 1'b0, '0);
    addInstr("add r0 reads zero", rType(cpuTypesPkg::FN_ADD, 0, 1, 11), 1'b1, 32'h5, 11, 1'b0, '0);
    // result held for three cycles of back-pressure
    addInstr("addi stalled", iType(cpuTypesPkg::OP_ADDI, 1, 12, 16'h0010), 1'b1,
             32'h15, 12, 1'b0, '0);
    addIdle(1'b0);
    addIdle(1'b0);
    addIdle(1'b0);
    addInstr("or after release", rType(cpuTypesPkg::FN_OR, 12, 0, 13), 1'b1, 32'h15, 13, 1'b0, '0);
    addInstr("add offered stalled", rType(cpuTypesPkg::FN_ADD, 13, 1, 14), 1'b0,
             32'h1A, 14, 1'b0, '0);
    addInstr("beq taken", iType(cpuTypesPkg::OP_BEQ, 1, 11, 16'h0004), 1'b1,
             32'h0, 0, 1'b1, 32'h0000_0150);
    addInstr("bne taken back", iType(cpuTypesPkg::OP_BNE, 1, 2, 16'hFFFC), 1'b1,
             32'h0, 0, 1'b1, 32'h0000_0144);
    addInstr("beq not taken", iType(cpuTypesPkg::OP_BEQ, 1, 2, 16'h0005), 1'b1, 32'h0, 0, 1'b0, '0);
    addInstr("bne not taken", iType(cpuTypesPkg::OP_BNE, 1, 11, 16'h0005), 1'b1,
             32'h0, 0, 1'b0, '0);
    addInstr("jump", {cpuTypesPkg::OP_J, 26'h000_0080}, 1'b1, 32'h0, 0, 1'b1, 32'h0000_0200);
    addInstr("addi after jump", iType(cpuTypesPkg::OP_ADDI, 7, 15, 16'h7FFF), 1'b1,
             32'h8000, 15, 1'b0, '0);
    // read back every low register with random fetch gaps and stalls
    rngState = 32'd73;
    for (int k = 0; k < `NUM_REGS / 2; k++)
    begin
      rngState = xorshift(rngState);
      if (rngState[0])
        addIdle(rngState[1]);
      addInstr($sformatf("readback r%0d", k), rType(cpuTypesPkg::FN_OR, k, 0, k), rngState[2],
               refRegs[k], k, 1'b0, '0);
    end
  endtask

  // ****************************************
  // table applied one fetch offer per row
  // ****************************************
  initial
  begin : stimulus
    rowT                row;
    rowT                expRow;
    string              who;
    int                 rowIdx;
    bit                 firstCycle;
    bit                 accepted;
    bit                 taken;
    bit                 held;
    cpuTypesPkg::wordT  heldData;
    cpuTypesPkg::wordT  heldPc;
    logic [`REG_AW-1:0] heldDest;
    logic               heldRedir;
    CLK        = 1'b0;
    nRST       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    pc         = '0;
    resReady   = 1'b0;
    for (int i = 0; i < `NUM_REGS; i++)
      refRegs[i] = '0;
    buildTable();
    cycleLimit = rows.size() * 4 + 50;
    repeat (5) @(posedge CLK);
    #1 nRST = 1'b1;
    @(negedge CLK);
    checkFlag("reset resValid", 1'b0, resValid);
    checkFlag("reset redirectValid", 1'b0, redirectValid);
    checkFlag("reset instrReady", 1'b1, instrReady);
    rowIdx     = 0;
    firstCycle = 1'b1;
    held       = 1'b0;
    while (rowIdx < rows.size() || pending.size() != 0)
    begin
      @(posedge CLK);
      #1;
      if (rowIdx < rows.size())
      begin
        row        = rows[rowIdx];
        instrValid = row.valid;
        instr      = row.instr;
        pc         = row.pc;
        resReady   = firstCycle ? row.ready : 1'b1;
      end
      else
      begin
        instrValid = 1'b0;   // draining the last result
        resReady   = 1'b1;
      end
      @(negedge CLK);
      if (held)
      begin
        checkFlag("held resValid", 1'b1, resValid);
        checkWord("held resData", heldData, resData);
        checkDest("held resDest", heldDest, resDest);
        checkWord("held resPc", heldPc, resPc);
        checkFlag("held redirectValid", heldRedir, redirectValid);
      end
      if (pending.size() != 0)
      begin
        expRow = rows[pending[0]];
        who    = names[pending[0]];
        checkFlag({who, " resValid"}, 1'b1, resValid);
        checkWord({who, " resData"}, expRow.expData, resData);
        checkDest({who, " resDest"}, expRow.expDest, resDest);
        checkWord({who, " resPc"}, expRow.pc, resPc);
        checkFlag({who, " redirectValid"}, expRow.expRedir, redirectValid);
        if (expRow.expRedir)
        begin
          checkWord({who, " redirectPc"}, expRow.expTarget, redirectPc);
          checkFlag({who, " instrReady"}, 1'b0, instrReady);
        end
      end
      else
        checkFlag("no result expected resValid", 1'b0, resValid);
      held = resValid && !resReady;
      if (held)
      begin
        checkFlag("stalled instrReady", 1'b0, instrReady);
        heldData  = resData;
        heldDest  = resDest;
        heldPc    = resPc;
        heldRedir = redirectValid;
      end
      accepted = instrValid && instrReady;
      taken    = resValid && resReady;
      if (taken)
        pending.delete(0);
      if (accepted)
        pending.push_back(rowIdx);
      if (rowIdx < rows.size())
      begin
        if (accepted || !row.valid)
        begin
          rowIdx++;
          firstCycle = 1'b1;
        end
        else
          firstCycle = 1'b0;   // keep offering, stall released
      end
    end
    // the last handshake completes at the next edge, then execute has to stay empty
    repeat (3)
    begin
      @(posedge CLK);
      #1;
      instrValid = 1'b0;
      resReady   = 1'b1;
      @(negedge CLK);
      checkFlag("drained resValid", 1'b0, resValid);
    end
    checkWord("result count", cpuTypesPkg::wordT'(validRows),
              cpuTypesPkg::wordT'(takenCount));
    checkWord("accepted count", cpuTypesPkg::wordT'(validRows),
              cpuTypesPkg::wordT'(acceptedCount));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
